// File: Makefile
VERILATOR  ?= verilator
TOP        := phold_engine_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall -Wno-fatal --timing --assert --top-module $(TOP)

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

# the run's exit status carries pass or fail.
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
source/phold_pkg.sv
source/event_fifo.sv
source/lfsr_rng.sv
source/lp_state_mem.sv
source/phold_core.sv
source/phold_engine.sv
tb/phold_engine_asserts.sv
tb/phold_engine_tb.sv

// File: source/event_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module event_fifo (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  in_valid,
	output logic                 in_ready,
	input  phold_pkg::lp_id_t    in_lp,
	input  phold_pkg::sim_time_t in_time,
	output logic                 pop_valid,
	input  wire                  pop,
	output phold_pkg::lp_id_t    pop_lp,
	output phold_pkg::sim_time_t pop_time
);

	phold_pkg::lp_id_t lp_mem [phold_pkg::FIFO_DEPTH];
	phold_pkg::sim_time_t time_mem [phold_pkg::FIFO_DEPTH];

	logic [phold_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [phold_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [phold_pkg::FIFO_CNT_W-1:0] count;
	logic push;
	logic take;

	assign in_ready = (count != phold_pkg::FIFO_CNT_W'(phold_pkg::FIFO_DEPTH));
	assign pop_valid = (count != '0);
	assign push = in_valid && in_ready;
	assign take = pop && pop_valid;

	// the head entry is read straight from the array, so no read cycle is needed.
	assign pop_lp = lp_mem[rd_ptr];
	assign pop_time = time_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			lp_mem[wr_ptr] <= in_lp;
			time_mem[wr_ptr] <= in_time;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == phold_pkg::FIFO_PTR_W'(phold_pkg::FIFO_DEPTH - 1)) ?
					'0 : wr_ptr + 1'b1;
			end
			if (take) begin
				rd_ptr <= (rd_ptr == phold_pkg::FIFO_PTR_W'(phold_pkg::FIFO_DEPTH - 1)) ?
					'0 : rd_ptr + 1'b1;
			end
			if (push && !take)
				count <= count + 1'b1;
			else if (take && !push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/lfsr_rng.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_rng (
	input  wire             clk,
	input  wire             rst_n,
	input  wire             rnd_take,
	output phold_pkg::rnd_t rnd
);

	phold_pkg::rnd_t state;
	logic feedback;

	// taps 24, 23, 22 and 17 give a maximal length sequence.
	assign feedback = state[23] ^ state[22] ^ state[21] ^ state[16];

	assign rnd = state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= phold_pkg::LFSR_SEED;
		end else if (rnd_take) begin
			state <= {state[phold_pkg::RND_W-2:0], feedback};
		end
	end

endmodule

`default_nettype wire

// File: source/lp_state_mem.sv
`timescale 1ns/1ps
`default_nettype none

module lp_state_mem (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  rq_vld,
	input  phold_pkg::mc_cmd_t   rq_cmd,
	input  phold_pkg::lp_id_t    rq_adr,
	input  phold_pkg::lp_count_t rq_data,
	input  phold_pkg::lp_id_t    rq_tag,
	output logic                 rq_stall,
	output logic                 rs_vld,
	output phold_pkg::mc_cmd_t   rs_cmd,
	output phold_pkg::lp_count_t rs_data,
	output phold_pkg::lp_id_t    rs_tag
);

	phold_pkg::lp_count_t counters [phold_pkg::NUM_LP];

	logic s1_vld;
	logic s2_vld;
	phold_pkg::mc_cmd_t s1_cmd;
	phold_pkg::mc_cmd_t s2_cmd;
	phold_pkg::lp_count_t s1_data;
	phold_pkg::lp_count_t s2_data;
	phold_pkg::lp_id_t s1_tag;
	phold_pkg::lp_id_t s2_tag;
	logic accept;
	logic is_wr;

	// only one request may be in flight, so stall until the response has gone out.
	assign rq_stall = s1_vld || s2_vld;
	assign accept = rq_vld && !rq_stall;
	assign is_wr = (rq_cmd == phold_pkg::MC_CMD_WR);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < phold_pkg::NUM_LP; i++)
				counters[i] <= '0;
			s1_vld <= 1'b0;
			s2_vld <= 1'b0;
		end else begin
			if (accept && is_wr)
				counters[rq_adr] <= rq_data;
			s1_vld <= accept;
			s2_vld <= s1_vld;
		end
	end

	always_ff @(posedge clk) begin
		s1_cmd <= is_wr ? phold_pkg::MC_RS_WR_CMP : phold_pkg::MC_RS_RD_DATA;
		s1_data <= is_wr ? rq_data : counters[rq_adr];
		s1_tag <= rq_tag;
		s2_cmd <= s1_cmd;
		s2_data <= s1_data;
		s2_tag <= s1_tag;
	end

	assign rs_vld = s2_vld;
	assign rs_cmd = s2_cmd;
	assign rs_data = s2_data;
	assign rs_tag = s2_tag;

endmodule

`default_nettype wire

// File: source/phold_core.sv
`timescale 1ns/1ps
`default_nettype none

module phold_core (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  pop_valid,
	output logic                 pop,
	input  phold_pkg::lp_id_t    pop_lp,
	input  phold_pkg::sim_time_t pop_time,
	input  phold_pkg::rnd_t      rnd,
	output logic                 rnd_take,
	output logic                 rq_vld,
	output phold_pkg::mc_cmd_t   rq_cmd,
	output phold_pkg::lp_id_t    rq_adr,
	output phold_pkg::lp_count_t rq_data,
	output phold_pkg::lp_id_t    rq_tag,
	input  wire                  rq_stall,
	input  wire                  rs_vld,
	input  phold_pkg::mc_cmd_t   rs_cmd,
	input  phold_pkg::lp_count_t rs_data,
	input  phold_pkg::lp_id_t    rs_tag,
	output logic                 out_valid,
	input  wire                  out_ready,
	output phold_pkg::lp_id_t    out_lp,
	output phold_pkg::sim_time_t out_time,
	output phold_pkg::lp_id_t    out_src_lp,
	output phold_pkg::lp_count_t out_count
);

	phold_pkg::core_state_t state;

	// the event being processed and the random value drawn for it.
	phold_pkg::lp_id_t ev_lp;
	phold_pkg::sim_time_t ev_time;
	phold_pkg::rnd_t ev_rnd;
	phold_pkg::lp_count_t count_q;
	phold_pkg::lp_id_t tag_q;

	phold_pkg::sim_time_t delay;
	logic rq_accept;
	logic rs_match;

	assign pop = (state == phold_pkg::IDLE) && pop_valid;
	assign rnd_take = pop;

	assign rq_vld = (state == phold_pkg::RD_REQ) || (state == phold_pkg::WR_REQ);
	assign rq_cmd = (state == phold_pkg::WR_REQ) ? phold_pkg::MC_CMD_WR : phold_pkg::MC_CMD_RD;
	assign rq_adr = ev_lp;
	assign rq_data = count_q;
	assign rq_tag = tag_q;
	assign rq_accept = rq_vld && !rq_stall;

	// a response only counts when it carries the tag of our own request.
	assign rs_match = rs_vld && (rs_tag == tag_q);

	// delay lies in 1 to 256, so an event never lands on its own timestamp.
	assign delay = phold_pkg::sim_time_t'(ev_rnd[phold_pkg::DELAY_W-1:0]) + 1'b1;

	assign out_valid = (state == phold_pkg::EMIT);
	assign out_lp = ev_rnd[phold_pkg::RND_W-1 -: phold_pkg::LP_ID_W];
	assign out_time = ev_time + delay;
	assign out_src_lp = ev_lp;
	assign out_count = count_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= phold_pkg::IDLE;
			tag_q <= '0;
		end else begin
			unique case (state)
				phold_pkg::IDLE: begin
					if (pop_valid)
						state <= phold_pkg::RD_REQ;
				end
				phold_pkg::RD_REQ: begin
					if (rq_accept)
						state <= phold_pkg::RD_WAIT;
				end
				phold_pkg::RD_WAIT: begin
					if (rs_match && rs_cmd == phold_pkg::MC_RS_RD_DATA) begin
						state <= phold_pkg::WR_REQ;
						tag_q <= tag_q + 1'b1;
					end
				end
				phold_pkg::WR_REQ: begin
					if (rq_accept)
						state <= phold_pkg::WR_WAIT;
				end
				phold_pkg::WR_WAIT: begin
					if (rs_match && rs_cmd == phold_pkg::MC_RS_WR_CMP) begin
						state <= phold_pkg::EMIT;
						tag_q <= tag_q + 1'b1;
					end
				end
				phold_pkg::EMIT: begin
					if (out_ready)
						state <= phold_pkg::IDLE;
				end
				default: begin
					state <= phold_pkg::IDLE;
				end
			endcase
		end
	end

	// payload registers load only in the state that owns them.
	always_ff @(posedge clk) begin
		if (pop) begin
			ev_lp <= pop_lp;
			ev_time <= pop_time;
			ev_rnd <= rnd;
		end
		if (state == phold_pkg::RD_WAIT && rs_match && rs_cmd == phold_pkg::MC_RS_RD_DATA)
			count_q <= rs_data + 1'b1;
	end

endmodule

`default_nettype wire

// File: source/phold_engine.sv
`timescale 1ns/1ps
`default_nettype none

module phold_engine (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  in_valid,
	output logic                 in_ready,
	input  phold_pkg::lp_id_t    in_lp,
	input  phold_pkg::sim_time_t in_time,
	output logic                 out_valid,
	input  wire                  out_ready,
	output phold_pkg::lp_id_t    out_lp,
	output phold_pkg::sim_time_t out_time,
	output phold_pkg::lp_id_t    out_src_lp,
	output phold_pkg::lp_count_t out_count
);

	logic pop_valid;
	logic pop;
	phold_pkg::lp_id_t pop_lp;
	phold_pkg::sim_time_t pop_time;

	phold_pkg::rnd_t rnd;
	logic rnd_take;

	logic rq_vld;
	logic rq_stall;
	phold_pkg::mc_cmd_t rq_cmd;
	phold_pkg::lp_id_t rq_adr;
	phold_pkg::lp_count_t rq_data;
	phold_pkg::lp_id_t rq_tag;

	logic rs_vld;
	phold_pkg::mc_cmd_t rs_cmd;
	phold_pkg::lp_count_t rs_data;
	phold_pkg::lp_id_t rs_tag;

	event_fifo i_event_fifo (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_ready(in_ready), .in_lp(in_lp), .in_time(in_time),
		.pop_valid(pop_valid), .pop(pop), .pop_lp(pop_lp), .pop_time(pop_time)
	);

	lfsr_rng i_lfsr_rng (
		.clk(clk), .rst_n(rst_n), .rnd_take(rnd_take), .rnd(rnd)
	);

	phold_core i_phold_core (
		.clk(clk), .rst_n(rst_n),
		.pop_valid(pop_valid), .pop(pop), .pop_lp(pop_lp), .pop_time(pop_time),
		.rnd(rnd), .rnd_take(rnd_take),
		.rq_vld(rq_vld), .rq_cmd(rq_cmd), .rq_adr(rq_adr), .rq_data(rq_data),
		.rq_tag(rq_tag), .rq_stall(rq_stall),
		.rs_vld(rs_vld), .rs_cmd(rs_cmd), .rs_data(rs_data), .rs_tag(rs_tag),
		.out_valid(out_valid), .out_ready(out_ready), .out_lp(out_lp),
		.out_time(out_time), .out_src_lp(out_src_lp), .out_count(out_count)
	);

	// on-chip stand-in for the external memory with a fixed latency.
	lp_state_mem i_lp_state_mem (
		.clk(clk), .rst_n(rst_n),
		.rq_vld(rq_vld), .rq_cmd(rq_cmd), .rq_adr(rq_adr), .rq_data(rq_data),
		.rq_tag(rq_tag), .rq_stall(rq_stall),
		.rs_vld(rs_vld), .rs_cmd(rs_cmd), .rs_data(rs_data), .rs_tag(rs_tag)
	);

endmodule

`default_nettype wire

// File: source/phold_pkg.sv
`default_nettype none

package phold_pkg;

	// widths of the event and state fields.
	localparam int LP_ID_W = 3;
	localparam int TIME_W = 16;
	localparam int RND_W = 24;
	localparam int COUNT_W = 16;
	localparam int DELAY_W = 8;
	localparam int NUM_LP = 1 << LP_ID_W;

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	typedef logic [LP_ID_W-1:0] lp_id_t;
	typedef logic [TIME_W-1:0] sim_time_t;
	typedef logic [RND_W-1:0] rnd_t;
	typedef logic [COUNT_W-1:0] lp_count_t;
	typedef logic [2:0] mc_cmd_t;

	// request codes on rq_cmd and the matching response codes on rs_cmd.
	localparam mc_cmd_t MC_CMD_RD = 3'd1;
	localparam mc_cmd_t MC_CMD_WR = 3'd2;
	localparam mc_cmd_t MC_RS_RD_DATA = 3'd2;
	localparam mc_cmd_t MC_RS_WR_CMP = 3'd3;

	localparam rnd_t LFSR_SEED = 24'h00_0001;

	typedef enum logic [2:0] {
		IDLE,
		RD_REQ,
		RD_WAIT,
		WR_REQ,
		WR_WAIT,
		EMIT
	} core_state_t;

endpackage

`default_nettype wire

// File: tb/phold_engine_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module phold_core_asserts (
	input wire                  clk,
	input wire                  rst_n,
	input wire                  pop,
	input wire                  rq_vld,
	input wire                  rq_stall,
	input phold_pkg::lp_id_t    rq_tag,
	input wire                  rs_vld,
	input phold_pkg::lp_id_t    rs_tag,
	input wire                  out_valid,
	input wire                  out_ready,
	input phold_pkg::lp_id_t    out_lp,
	input phold_pkg::sim_time_t out_time,
	input phold_pkg::lp_id_t    out_src_lp,
	input phold_pkg::lp_count_t out_count
);

	logic pending;
	phold_pkg::lp_id_t pending_tag;

	// tracks the one memory request that has been accepted and not yet answered.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else if (rq_vld && !rq_stall) begin
			pending <= 1'b1;
			pending_tag <= rq_tag;
		end else if (rs_vld) begin
			pending <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_lp) && $stable(out_time)
			&& $stable(out_src_lp) && $stable(out_count))
		else $error("output event changed while out_ready was low");

	assert property (@(posedge clk) disable iff (!rst_n) rq_vld && !rq_stall |-> !pending)
		else $error("memory request accepted while a response was pending");

	assert property (@(posedge clk) disable iff (!rst_n)
		rs_vld |-> pending && rs_tag == pending_tag)
		else $error("memory response tag differs from the outstanding request");

	// a pop lasts one cycle and the read request for the popped event follows it.
	assert property (@(posedge clk) disable iff (!rst_n) pop |=> !pop && rq_vld)
		else $error("pop was not a single pulse followed by a read request");

endmodule

bind phold_core phold_core_asserts i_phold_core_asserts (.*);

`default_nettype wire

// File: tb/phold_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module phold_engine_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_RANDOM = 200;
	// one single, six counter and at most ten back-pressure events come before the random run.
	localparam int MAX_EVENTS = 17 + NUM_RANDOM;
	localparam logic [31:0] SEED = 32'h386d_0c79;

	typedef struct packed {
		phold_pkg::lp_id_t lp;
		phold_pkg::sim_time_t t;
		phold_pkg::lp_id_t src;
		phold_pkg::lp_count_t count;
	} exp_event_t;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	phold_pkg::lp_id_t in_lp;
	phold_pkg::sim_time_t in_time;
	logic out_valid;
	logic out_ready;
	phold_pkg::lp_id_t out_lp;
	phold_pkg::sim_time_t out_time;
	phold_pkg::lp_id_t out_src_lp;
	phold_pkg::lp_count_t out_count;

	exp_event_t exp_q [$];
	phold_pkg::rnd_t model_rnd;
	phold_pkg::lp_count_t model_count [phold_pkg::NUM_LP];
	int sent_count = 0;
	int checked_count = 0;
	int ready_mode = 0;
	logic [31:0] stim_rng;
	logic [31:0] ready_rng;

	phold_engine i_phold_engine (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic phold_pkg::rnd_t lfsr_step(input phold_pkg::rnd_t r);
		return {r[22:0], r[23] ^ r[22] ^ r[21] ^ r[16]};
	endfunction

	// expected output for an event, given its random value and the counter before it.
	function automatic exp_event_t predict_event(input phold_pkg::lp_id_t lp,
			input phold_pkg::sim_time_t t, input phold_pkg::rnd_t r,
			input phold_pkg::lp_count_t cnt);
		exp_event_t e;
		e.lp = r[23:21];
		e.t = t + 16'(r[7:0]) + 16'd1;
		e.src = lp;
		e.count = cnt + 16'd1;
		return e;
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_lp(input string what, input phold_pkg::lp_id_t got, exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
	endtask

	task automatic check_time(input string what, input phold_pkg::sim_time_t got, exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
	endtask

	task automatic check_count(input string what, input phold_pkg::lp_count_t got, exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// called 2 ns after an edge, when in_ready is stable and shows
	// whether the next edge takes the event.
	task automatic send_event(input phold_pkg::lp_id_t lp, input phold_pkg::sim_time_t t);
		logic taken;
		in_valid = 1'b1;
		in_lp = lp;
		in_time = t;
		taken = 1'b0;
		while (!taken) begin
			taken = in_ready;
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
		exp_q.push_back(predict_event(lp, t, model_rnd, model_count[lp]));
		model_count[lp] = model_count[lp] + 16'd1;
		model_rnd = lfsr_step(model_rnd);
		sent_count++;
	endtask

	task automatic wait_drained();
		wait (checked_count == sent_count);
		@(posedge clk);
		#2;
	endtask

	initial begin : clock_gen
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2);
			clk = ~clk;
		end
	end

	// mode 0 keeps out_ready high, mode 1 holds it low, mode 2 lowers it about a quarter of the time.
	initial begin : ready_drive
		out_ready = 1'b1;
		ready_rng = ~SEED;
		forever begin
			@(posedge clk);
			#2;
			ready_rng = lcg_next(ready_rng);
			case (ready_mode)
				1: out_ready = 1'b0;
				2: out_ready = (ready_rng[31:30] != 2'b00);
				default: out_ready = 1'b1;
			endcase
		end
	end

	// outputs and out_ready are both stable at the falling edge.
	initial begin : compare
		exp_event_t e;
		forever begin
			@(negedge clk);
			if (rst_n && out_valid && out_ready) begin
				if (exp_q.size() == 0)
					abort_run("an output event arrived that no input event accounts for");
				e = exp_q.pop_front();
				check_lp("out_lp", out_lp, e.lp);
				check_time("out_time", out_time, e.t);
				check_lp("out_src_lp", out_src_lp, e.src);
				check_count("out_count", out_count, e.count);
				checked_count++;
			end
		end
	end

	initial begin : watchdog
		#(CLK_PERIOD * (RESET_CYCLES + MAX_EVENTS * 40));
		abort_run("watchdog expired because outputs stopped arriving");
	end

	initial begin : stimulus
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_lp = '0;
		in_time = '0;
		stim_rng = SEED;
		model_rnd = phold_pkg::LFSR_SEED;
		for (int i = 0; i < phold_pkg::NUM_LP; i++)
			model_count[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_flag("out_valid after reset", out_valid, 1'b0);
		check_flag("in_ready after reset", in_ready, 1'b1);

		send_event(3'd3, 16'd100);
		wait_drained();

		// four events to process 5, then two to process 2.
		for (int i = 0; i < 6; i++)
			send_event((i < 4) ? 3'd5 : 3'd2, 16'(200 + 10 * i));
		wait_drained();

		ready_mode = 1;
		repeat (2) @(posedge clk);
		#2;
		for (int i = 0; i < 10 && in_ready; i++) begin
			stim_rng = lcg_next(stim_rng);
			send_event(stim_rng[31:29], stim_rng[27:12]);
		end
		check_flag("in_ready under back-pressure", in_ready, 1'b0);
		repeat (10) @(posedge clk);
		#2;
		ready_mode = 0;
		wait_drained();

		// some times sit just below the top of the range so that the new time wraps.
		ready_mode = 2;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			stim_rng = lcg_next(stim_rng);
			repeat (stim_rng[11:10]) begin
				@(posedge clk);
				#2;
			end
			send_event(stim_rng[31:29], stim_rng[28] ? {8'hff, stim_rng[23:16]} : stim_rng[27:12]);
		end
		ready_mode = 0;
		wait_drained();
		repeat (20) @(posedge clk);

		if (checked_count == sent_count && exp_q.size() == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			abort_run("the run ended with expected events still undelivered");
		end
	end

endmodule

`default_nettype wire
